//--- dv/fcb_tb.sv
// **********************************************************************
// Directed testbench for the configuration command path
// Clock, reset, LFSR data, compare tasks, tests, watchdog, final report
// **********************************************************************

`timescale 1ns/100ps

module fcb_tb;

  import fcb_pkg::*;

  localparam int          CLK_PERIOD  = 40;
  localparam int          DRIVE_DLY   = 5;    // Inputs change after the edge
  localparam int          NUM_TESTS   = 5;
  localparam int          WATCHDOG_NS = NUM_TESTS * 400 * CLK_PERIOD;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic               fcb_sys_clk;
  logic               fcb_sys_rst_n;
  logic               pif_on;
  fcb_cmd_t           pif_wr_cmd;
  logic               pif_wr_en;
  logic               pif_crf_rd_en;
  logic               apb_on;
  fcb_cmd_t           apb_wr_cmd;
  logic               apb_wr_en;
  logic               apb_crf_rd_en;
  logic               wff_full;
  logic               wff_full_m1;
  logic               wff_ff0_of;
  logic               crf_empty;
  logic               crf_empty_p1;
  fcb_word_t          crf_rd_data;

  logic [31:0]        lfsr_q;                 // Random source state
  fcb_sfr_data_t      sfr_exp [FCB_SFR_COUNT]; // Expected SFR contents
  fcb_word_t          cfg_q [$];              // Cfg words in send order
  int                 chk_cnt;
  int                 err_cnt;

  fcb_top fcb_top_inst (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_on        (pif_on),
    .pif_wr_cmd    (pif_wr_cmd),
    .pif_wr_en     (pif_wr_en),
    .pif_crf_rd_en (pif_crf_rd_en),
    .apb_on        (apb_on),
    .apb_wr_cmd    (apb_wr_cmd),
    .apb_wr_en     (apb_wr_en),
    .apb_crf_rd_en (apb_crf_rd_en),
    .wff_full      (wff_full),
    .wff_full_m1   (wff_full_m1),
    .wff_ff0_of    (wff_ff0_of),
    .crf_empty     (crf_empty),
    .crf_empty_p1  (crf_empty_p1),
    .crf_rd_data   (crf_rd_data)
  );

  initial begin
    fcb_sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fcb_sys_clk = ~fcb_sys_clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic fcb_cmd_t make_cmd(input logic wr, input fcb_sfr_addr_t addr,
                                        input fcb_word_t data);
    fcb_cmd_t c;
    c.wr   = wr;
    c.addr = addr;
    c.data = data;
    return c;
  endfunction

  task automatic check_word(input string name, input fcb_word_t act, input fcb_word_t exp);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, act, exp);
    end
  endtask

  task automatic check_sfr(input string name, input fcb_sfr_data_t act,
                           input fcb_sfr_data_t exp);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge fcb_sys_clk);
    #DRIVE_DLY;
  endtask

  task automatic clear_inputs();
    pif_wr_cmd    = '0;
    pif_wr_en     = 1'b0;
    pif_crf_rd_en = 1'b0;
    apb_wr_cmd    = '0;
    apb_wr_en     = 1'b0;
    apb_crf_rd_en = 1'b0;
  endtask

  // Hold reset 10 cycles, model back to its reset state
  task automatic apply_reset();
    fcb_sys_rst_n = 1'b0;
    clear_inputs();
    for (int i = 0; i < FCB_SFR_COUNT; i++) begin
      sfr_exp[i] = '0;
    end
    cfg_q.delete();
    repeat (10) next_cycle();
    fcb_sys_rst_n = 1'b1;
    next_cycle();
  endtask

  // One-cycle host write, overflow flag checked while enable is up
  task automatic drive_cmd(input logic use_apb, input fcb_cmd_t c, input logic exp_of);
    if (use_apb) begin
      apb_wr_cmd = c;
      apb_wr_en  = 1'b1;
    end else begin
      pif_wr_cmd = c;
      pif_wr_en  = 1'b1;
    end
    #1;
    check_flag("wff_ff0_of", wff_ff0_of, exp_of);
    next_cycle();
    clear_inputs();
  endtask

  task automatic send_cmd(input logic use_apb, input fcb_cmd_t c);
    while (wff_full) next_cycle();  // Room in write FIFO
    drive_cmd(use_apb, c, 1'b0);
  endtask

  task automatic pop_word(input logic use_apb);
    if (use_apb) apb_crf_rd_en = 1'b1;
    else pif_crf_rd_en = 1'b1;
    next_cycle();
    clear_inputs();
  endtask

  task automatic wait_word();
    while (crf_empty) next_cycle();  // Watchdog bounds this
  endtask

  task automatic write_sfr(input logic use_apb, input fcb_sfr_addr_t addr,
                           input fcb_word_t data);
    if (int'(addr) < FCB_SFR_COUNT) sfr_exp[addr[3:0]] = data[7:0];  // Low byte kept
    send_cmd(use_apb, make_cmd(1'b1, addr, data));
  endtask

  task automatic read_sfr(input logic cmd_apb, input logic pop_apb,
                          input fcb_sfr_addr_t addr, input fcb_sfr_data_t exp);
    send_cmd(cmd_apb, make_cmd(1'b0, addr, '0));
    wait_word();
    check_sfr("crf_rd_data[7:0]", crf_rd_data[7:0], exp);
    check_flag("crf_rd_data[31:8] zero", crf_rd_data[31:8] == '0, 1'b1);
    pop_word(pop_apb);
  endtask

  task automatic send_cfg(input logic use_apb);
    fcb_word_t w;
    w = rand_bits(32);
    cfg_q.push_back(w);
    send_cmd(use_apb, make_cmd(1'b1, FCB_CFG_DATA_ADDR, w));
  endtask

  task automatic start_readback(input logic use_apb, input int n);
    send_cmd(use_apb, make_cmd(1'b1, FCB_RDBK_CMD_ADDR, fcb_word_t'(n)));
  endtask

  // Pop n cfg words, first arrival always leaves exactly one held
  task automatic collect_words(input logic pop_apb, input int n, input logic hold_check);
    fcb_word_t exp;
    for (int i = 0; i < n; i++) begin
      wait_word();
      if (i == 0) begin
        check_flag("crf_empty_p1", crf_empty_p1, 1'b1);
        if (hold_check && n > 1) begin
          next_cycle();  // Engine adds a second word
          check_flag("crf_empty_p1", crf_empty_p1, 1'b0);
        end
      end
      exp = cfg_q.pop_front();
      check_word("crf_rd_data", crf_rd_data, exp);
      pop_word(pop_apb);
    end
  endtask

  task automatic test_sfr_round_trip();
    for (int i = 0; i < 4; i++) write_sfr(1'b0, fcb_sfr_addr_t'(i * 5), rand_bits(32));
    for (int i = 0; i < 4; i++) read_sfr(1'b1, 1'b1, fcb_sfr_addr_t'(i * 5), sfr_exp[i * 5]);
    for (int i = 0; i < 3; i++) write_sfr(1'b1, fcb_sfr_addr_t'(i * 4 + 2), rand_bits(32));
    for (int i = 0; i < 3; i++) begin
      read_sfr(1'b0, 1'b0, fcb_sfr_addr_t'(i * 4 + 2), sfr_exp[i * 4 + 2]);
    end
    read_sfr(1'b1, 1'b0, 7'h10, 8'h00);  // Unimplemented
    read_sfr(1'b0, 1'b1, 7'h7f, 8'h00);
  endtask

  task automatic test_cfg_readback_order();
    repeat (4) send_cfg(1'b1);
    start_readback(1'b1, 3);
    collect_words(1'b1, 3, 1'b1);
    check_flag("crf_empty", crf_empty, 1'b1);
    read_sfr(1'b1, 1'b1, FCB_RDBK_CMD_ADDR, 8'h00);  // Count ran down
    start_readback(1'b1, 1);                        // Drain fourth word
    collect_words(1'b1, 1, 1'b0);
  endtask

  task automatic test_cfg_back_pressure();
    fcb_word_t va;
    fcb_word_t vb;
    pif_on = 1'b0;
    apb_on = 1'b0;
    start_readback(1'b0, 5);  // Loaded but gated off
    repeat (4) send_cfg(1'b0);
    send_cfg(1'b0);           // Fifth stalls at head
    va = rand_bits(32);
    write_sfr(1'b0, 7'h03, va);
    while (!wff_full) next_cycle();
    vb = ~va;                 // Low byte differs from the accepted write
    drive_cmd(1'b0, make_cmd(1'b1, 7'h03, vb), 1'b1);  // Lost write
    pif_on = 1'b1;
    collect_words(1'b0, 5, 1'b0);
    read_sfr(1'b0, 1'b0, 7'h03, sfr_exp[3]);
    apb_on = 1'b1;
  endtask

  task automatic test_path_gating();
    pif_on = 1'b0;
    apb_on = 1'b0;
    send_cfg(1'b1);
    send_cfg(1'b1);
    start_readback(1'b1, 2);
    repeat (20) begin
      next_cycle();
      check_flag("crf_empty", crf_empty, 1'b1);
    end
    pif_on = 1'b1;
    collect_words(1'b0, 2, 1'b0);
    apb_on = 1'b1;
  endtask

  task automatic test_reset_state();
    write_sfr(1'b0, 7'h09, rand_bits(32) | 32'h0000_0080);
    start_readback(1'b0, 7);  // Count held, cfg FIFO is empty
    send_cmd(1'b0, make_cmd(1'b0, 7'h09, '0));
    wait_word();  // Leave a word in the read-back FIFO
    send_cmd(1'b0, make_cmd(1'b1, 7'h09, 32'h0000_005a));  // Still queued at reset
    check_flag("wff_full_m1", wff_full_m1, 1'b1);
    apply_reset();
    check_flag("wff_full", wff_full, 1'b0);
    check_flag("wff_full_m1", wff_full_m1, 1'b0);
    check_flag("wff_ff0_of", wff_ff0_of, 1'b0);
    check_flag("crf_empty", crf_empty, 1'b1);
    check_flag("crf_empty_p1", crf_empty_p1, 1'b0);
    read_sfr(1'b0, 1'b0, 7'h09, 8'h00);
    read_sfr(1'b1, 1'b1, FCB_RDBK_CMD_ADDR, 8'h00);
  endtask

  task automatic report_counts();
    $display("Checks: %0d  errors: %0d", chk_cnt, err_cnt);
  endtask

  initial begin
    lfsr_q        = 32'he97f;
    chk_cnt       = 0;
    err_cnt       = 0;
    fcb_sys_rst_n = 1'b0;
    pif_on        = 1'b1;
    apb_on        = 1'b1;
    clear_inputs();
    apply_reset();
    test_sfr_round_trip();
    test_cfg_readback_order();
    test_cfg_back_pressure();
    test_path_gating();
    test_reset_state();
    repeat (2) next_cycle();
    report_counts();
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the test count
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: timeout, tests still running at %0t", $time);
    report_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- rtl/fcb_pkg.sv
// **********************************************************************
// Shared types and constants of the configuration command path
// Command struct, word and SFR typedefs, fixed SFR addresses
// **********************************************************************

package fcb_pkg;

  // Configuration or read-back word
  typedef logic [31:0] fcb_word_t;

  // SFR address as carried in a command
  typedef logic [6:0] fcb_sfr_addr_t;

  // SFR value
  typedef logic [7:0] fcb_sfr_data_t;

  // Host command word, 40 bits
  // wr is bit 39, addr bits 38:32, data bits 31:0
  typedef struct packed {
    logic          wr;    // 1 write, 0 SFR read
    fcb_sfr_addr_t addr;  // Target address
    fcb_word_t     data;  // Cfg word or SFR value in [7:0]
  } fcb_cmd_t;

  // Configuration data words go here
  localparam fcb_sfr_addr_t FCB_CFG_DATA_ADDR = 7'h20;

  // Readback count SFR
  localparam fcb_sfr_addr_t FCB_RDBK_CMD_ADDR = 7'h21;

  // Implemented SFRs at 0x00 to 0x0F
  localparam int FCB_SFR_COUNT = 16;

  // Widths for FIFO instances
  localparam int FCB_CMD_WIDTH  = $bits(fcb_cmd_t);
  localparam int FCB_WORD_WIDTH = $bits(fcb_word_t);

endpackage

//--- rtl/fcb_reg_unit.sv
// **********************************************************************
// SFR bank, configuration word FIFO and readback engine
// **********************************************************************

`timescale 1ns/100ps

module fcb_reg_unit #(
  parameter int CFG_FIFO_DEPTH_BITS = 2
) (
  input  logic                   fcb_sys_clk,
  input  logic                   fcb_sys_rst_n,
  input  fcb_pkg::fcb_cmd_t      cmd,          // Current dispatched command
  input  logic                   cfg_wr_en,
  input  logic                   sfr_wr_en,
  input  logic                   sfr_rd_en,
  input  logic                   path_on,      // Any host on
  output logic                   cfg_full,
  output fcb_pkg::fcb_sfr_data_t sfr_rd_data,  // Combinational from cmd.addr
  output logic                   crf_wr_en,    // Readback push
  output fcb_pkg::fcb_word_t     crf_wr_data,
  input  logic                   crf_full
);

  import fcb_pkg::*;

  localparam int SFR_IDX_BITS = $clog2(FCB_SFR_COUNT);

  fcb_sfr_data_t             sfr_q [FCB_SFR_COUNT];
  fcb_sfr_data_t             rdbk_cnt;   // Words still to read back
  logic                      sfr_hit;    // Address inside SFR bank
  logic [SFR_IDX_BITS-1:0]   sfr_idx;
  logic                      cfg_empty;

  assign sfr_hit = (cmd.addr < FCB_SFR_COUNT);
  assign sfr_idx = cmd.addr[SFR_IDX_BITS-1:0];

  // SFR writes, other addresses dropped
  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      for (int i = 0; i < FCB_SFR_COUNT; i++) begin
        sfr_q[i] <= '0;
      end
    end else if (sfr_wr_en && sfr_hit) begin
      sfr_q[sfr_idx] <= fcb_sfr_data_t'(cmd.data);  // Low byte only
    end
  end

  // Readback count, a new load overrides a decrement
  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      rdbk_cnt <= '0;
    end else if (sfr_wr_en && cmd.addr == FCB_RDBK_CMD_ADDR) begin
      rdbk_cnt <= fcb_sfr_data_t'(cmd.data);
    end else if (crf_wr_en) begin
      rdbk_cnt <= rdbk_cnt - 1'b1;
    end
  end

  // Read mux
  always_comb begin
    if (sfr_hit) begin
      sfr_rd_data = sfr_q[sfr_idx];
    end else if (cmd.addr == FCB_RDBK_CMD_ADDR) begin
      sfr_rd_data = rdbk_cnt;  // Remaining count
    end else begin
      sfr_rd_data = '0;
    end
  end

  // One word per cycle, SFR read has the read-back FIFO first
  assign crf_wr_en = (rdbk_cnt != '0) && !cfg_empty && !crf_full
                   && path_on && !sfr_rd_en;

  // Stand-in for the fabric loader
  fcb_sync_fifo #(
    .DATA_WIDTH (FCB_WORD_WIDTH),
    .DEPTH_BITS (CFG_FIFO_DEPTH_BITS)
  ) cfg_inst (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .wr_en         (cfg_wr_en),
    .wr_data       (cmd.data),
    .rd_en         (crf_wr_en),    // Pop as word moves to read-back
    .rd_data       (crf_wr_data),
    .empty         (cfg_empty),
    .empty_p1      (),
    .full          (cfg_full),
    .full_m1       ()
  );

endmodule

//--- rtl/fcb_rw_fifo.sv
// **********************************************************************
// Host command merge, write FIFO and dispatch FSM
// Read-back FIFO fed by SFR reads and the readback engine
// **********************************************************************

`timescale 1ns/100ps

module fcb_rw_fifo (
  input  logic                  fcb_sys_clk,
  input  logic                  fcb_sys_rst_n,
  input  logic                  pif_on,         // Parallel host active
  input  fcb_pkg::fcb_cmd_t     pif_wr_cmd,
  input  logic                  pif_wr_en,
  input  logic                  pif_crf_rd_en,  // Read-back pop
  input  logic                  apb_on,         // APB host active
  input  fcb_pkg::fcb_cmd_t     apb_wr_cmd,
  input  logic                  apb_wr_en,
  input  logic                  apb_crf_rd_en,
  output logic                  wff_full,
  output logic                  wff_full_m1,
  output logic                  wff_ff0_of,     // Host write dropped
  output logic                  crf_empty,
  output logic                  crf_empty_p1,
  output fcb_pkg::fcb_word_t    crf_rd_data,
  output fcb_pkg::fcb_cmd_t     cmd,            // Write FIFO head
  output logic                  cfg_wr_en,
  output logic                  sfr_wr_en,
  output logic                  sfr_rd_en,
  output logic                  path_on,
  input  logic                  cfg_full,       // Cfg FIFO cannot take a word
  input  fcb_pkg::fcb_sfr_data_t sfr_rd_data,
  input  logic                  crf_wr_en,      // Readback engine push
  input  fcb_pkg::fcb_word_t    crf_wr_data,
  output logic                  crf_full,
  output logic                  crf_full_m1
);

  import fcb_pkg::*;

  // Dispatch states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_CFG    = 2'b01,
    ST_SFR_WR = 2'b10,
    ST_SFR_RD = 2'b11
  } disp_state_t;

  disp_state_t             state_q;
  disp_state_t             state_d;
  logic [FCB_CMD_WIDTH-1:0] wff_wr_data;   // Merged host command
  logic                    wff_wr_en;
  logic                    wff_rd_en;
  logic                    wff_empty;
  fcb_word_t               crf_in_data;
  logic                    crf_in_en;
  logic                    crf_rd_en;

  // Hosts never overlap, so mask and OR
  assign wff_wr_data = (pif_wr_cmd & {FCB_CMD_WIDTH{pif_wr_en}})
                     | (apb_wr_cmd & {FCB_CMD_WIDTH{apb_wr_en}});
  assign wff_wr_en   = pif_wr_en | apb_wr_en;
  assign wff_ff0_of  = wff_full && wff_wr_en;  // Write lost this cycle

  assign path_on = pif_on | apb_on;

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d   = state_q;
    cfg_wr_en = 1'b0;
    sfr_wr_en = 1'b0;
    sfr_rd_en = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (!wff_empty) begin
          if (cmd.wr && cmd.addr == FCB_CFG_DATA_ADDR) begin
            if (!cfg_full) state_d = ST_CFG;  // Stall head while cfg FIFO full
          end else if (cmd.wr) begin
            state_d = ST_SFR_WR;
          end else begin
            state_d = ST_SFR_RD;
          end
        end
      end
      ST_CFG: begin
        cfg_wr_en = 1'b1;  // Push cfg word
        state_d   = ST_IDLE;
      end
      ST_SFR_WR: begin
        sfr_wr_en = 1'b1;
        state_d   = ST_IDLE;
      end
      ST_SFR_RD: begin
        sfr_rd_en = 1'b1;  // Read data lands in read-back FIFO
        state_d   = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Each strobe retires the head
  assign wff_rd_en = cfg_wr_en | sfr_wr_en | sfr_rd_en;

  fcb_sync_fifo #(
    .DATA_WIDTH (FCB_CMD_WIDTH),
    .DEPTH_BITS (1)
  ) wff_inst (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .wr_en         (wff_wr_en),
    .wr_data       (wff_wr_data),
    .rd_en         (wff_rd_en),
    .rd_data       (cmd),
    .empty         (wff_empty),
    .empty_p1      (),            // Not needed by dispatch
    .full          (wff_full),
    .full_m1       (wff_full_m1)
  );

  // SFR read wins, engine holds off during sfr_rd_en
  assign crf_in_data = sfr_rd_en ? fcb_word_t'(sfr_rd_data) : crf_wr_data;
  assign crf_in_en   = sfr_rd_en | crf_wr_en;
  assign crf_rd_en   = pif_crf_rd_en | apb_crf_rd_en;

  fcb_sync_fifo #(
    .DATA_WIDTH (FCB_WORD_WIDTH),
    .DEPTH_BITS (1)
  ) crf_inst (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .wr_en         (crf_in_en),
    .wr_data       (crf_in_data),
    .rd_en         (crf_rd_en),
    .rd_data       (crf_rd_data),
    .empty         (crf_empty),
    .empty_p1      (crf_empty_p1),
    .full          (crf_full),
    .full_m1       (crf_full_m1)
  );

endmodule

//--- rtl/fcb_sync_fifo.sv
// **********************************************************************
// Synchronous show-ahead FIFO with empty, empty+1, full, full-1 flags
// **********************************************************************

`timescale 1ns/100ps

module fcb_sync_fifo #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH_BITS = 1
) (
  input  logic                  fcb_sys_clk,
  input  logic                  fcb_sys_rst_n,
  input  logic                  wr_en,    // Push, ignored when full
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_en,    // Pop, ignored when empty
  output logic [DATA_WIDTH-1:0] rd_data,  // Head word, valid when not empty
  output logic                  empty,
  output logic                  empty_p1, // Exactly one entry
  output logic                  full,
  output logic                  full_m1   // One free slot left
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  // Pointers and count carry one extra bit
  typedef logic [DEPTH_BITS:0] ptr_t;

  localparam ptr_t PTR_ONE     = {{DEPTH_BITS{1'b0}}, 1'b1};
  localparam ptr_t FULL_CNT    = {1'b1, {DEPTH_BITS{1'b0}}};
  localparam ptr_t FULL_M1_CNT = FULL_CNT - PTR_ONE;

  logic [DATA_WIDTH-1:0] mem [DEPTH];  // Storage, no reset
  ptr_t                  wr_ptr;
  ptr_t                  rd_ptr;
  ptr_t                  count;       // Occupancy
  logic                  wr_ok;
  logic                  rd_ok;

  assign wr_ok = wr_en && !full;   // Drop writes on full
  assign rd_ok = rd_en && !empty;  // Drop reads on empty

  always_ff @(posedge fcb_sys_clk) begin
    if (wr_ok) begin
      mem[wr_ptr[DEPTH_BITS-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + PTR_ONE;
      if (rd_ok) rd_ptr <= rd_ptr + PTR_ONE;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + PTR_ONE;
        2'b01:   count <= count - PTR_ONE;
        default: count <= count;  // Both or neither, level unchanged
      endcase
    end
  end

  // Show-ahead head
  assign rd_data = mem[rd_ptr[DEPTH_BITS-1:0]];

  // Flags straight from occupancy
  assign empty    = (count == '0);
  assign empty_p1 = (count == PTR_ONE);
  assign full     = (count == FULL_CNT);
  assign full_m1  = (count == FULL_M1_CNT);

endmodule

//--- rtl/fcb_top.sv
// **********************************************************************
// Top level, command path joined to the register unit
// **********************************************************************

`timescale 1ns/100ps

module fcb_top #(
  parameter int CFG_FIFO_DEPTH_BITS = 2  // Cfg FIFO holds 4 words
) (
  input  logic               fcb_sys_clk,
  input  logic               fcb_sys_rst_n,
  input  logic               pif_on,
  input  fcb_pkg::fcb_cmd_t  pif_wr_cmd,
  input  logic               pif_wr_en,
  input  logic               pif_crf_rd_en,
  input  logic               apb_on,
  input  fcb_pkg::fcb_cmd_t  apb_wr_cmd,
  input  logic               apb_wr_en,
  input  logic               apb_crf_rd_en,
  output logic               wff_full,
  output logic               wff_full_m1,
  output logic               wff_ff0_of,
  output logic               crf_empty,
  output logic               crf_empty_p1,
  output fcb_pkg::fcb_word_t crf_rd_data
);

  import fcb_pkg::*;

  fcb_cmd_t      cmd;
  logic          cfg_wr_en;
  logic          sfr_wr_en;
  logic          sfr_rd_en;
  logic          path_on;
  logic          cfg_full;
  fcb_sfr_data_t sfr_rd_data;
  logic          crf_wr_en;    // Readback engine to read-back FIFO
  fcb_word_t     crf_wr_data;
  logic          crf_full;

  fcb_rw_fifo rw_fifo_inst (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_on        (pif_on),
    .pif_wr_cmd    (pif_wr_cmd),
    .pif_wr_en     (pif_wr_en),
    .pif_crf_rd_en (pif_crf_rd_en),
    .apb_on        (apb_on),
    .apb_wr_cmd    (apb_wr_cmd),
    .apb_wr_en     (apb_wr_en),
    .apb_crf_rd_en (apb_crf_rd_en),
    .wff_full      (wff_full),
    .wff_full_m1   (wff_full_m1),
    .wff_ff0_of    (wff_ff0_of),
    .crf_empty     (crf_empty),
    .crf_empty_p1  (crf_empty_p1),
    .crf_rd_data   (crf_rd_data),
    .cmd           (cmd),
    .cfg_wr_en     (cfg_wr_en),
    .sfr_wr_en     (sfr_wr_en),
    .sfr_rd_en     (sfr_rd_en),
    .path_on       (path_on),
    .cfg_full      (cfg_full),
    .sfr_rd_data   (sfr_rd_data),
    .crf_wr_en     (crf_wr_en),
    .crf_wr_data   (crf_wr_data),
    .crf_full      (crf_full),
    .crf_full_m1   ()            // Engine pushes one word at a time
  );

  fcb_reg_unit #(
    .CFG_FIFO_DEPTH_BITS (CFG_FIFO_DEPTH_BITS)
  ) reg_unit_inst (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .cmd           (cmd),
    .cfg_wr_en     (cfg_wr_en),
    .sfr_wr_en     (sfr_wr_en),
    .sfr_rd_en     (sfr_rd_en),
    .path_on       (path_on),
    .cfg_full      (cfg_full),
    .sfr_rd_data   (sfr_rd_data),
    .crf_wr_en     (crf_wr_en),
    .crf_wr_data   (crf_wr_data),
    .crf_full      (crf_full)
  );

endmodule

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and decide by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module fcb_tb -f tb.f -o fcb_sim \
  && ./obj_dir/fcb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }

//--- tb.f
rtl/fcb_pkg.sv
rtl/fcb_sync_fifo.sv
rtl/fcb_rw_fifo.sv
rtl/fcb_reg_unit.sv
rtl/fcb_top.sv
dv/fcb_tb.sv
